/* source/dcache_pkg.sv */
package dcache_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int WORD_WIDTH = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	localparam int OFFSET_WIDTH = $clog2(WORDS_PER_LINE);
	localparam int INDEX_WIDTH = $clog2(NUM_SETS);
	// byte offset inside a line
	localparam int LINE_OFFSET_WIDTH = OFFSET_WIDTH + 2;
	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - LINE_OFFSET_WIDTH;
	localparam int WAY_WIDTH = $clog2(NUM_WAYS);
	localparam int PLRU_WIDTH = NUM_WAYS - 1;
	localparam int VICTIM_DEPTH = 2;
	localparam int VICTIM_PTR_WIDTH = $clog2(VICTIM_DEPTH);

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef word_t [WORDS_PER_LINE-1:0] line_t;
	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;
	typedef logic [WAY_WIDTH-1:0] way_t;

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		EVICT,
		REFILL
	} ctrl_state_t;

	typedef struct packed {
		logic valid;
		logic write;
		logic [ADDR_WIDTH-1:0] addr;
		word_t wdata;
		logic [3:0] be;
	} cpu_req_t;

	typedef struct packed {
		logic valid;
		word_t rdata;
	} cpu_rsp_t;

	// one write into the tag and data arrays
	typedef struct packed {
		logic we;
		way_t way;
		index_t index;
		tag_t tag;
		line_t line;
		logic valid;
		logic dirty;
	} way_wr_t;

	typedef struct packed {
		logic valid;
		logic [ADDR_WIDTH-1:0] addr;
		line_t line;
	} victim_t;

	typedef struct packed {
		logic valid;
		logic [ADDR_WIDTH-1:0] addr;
	} fill_req_t;

	typedef struct packed {
		logic valid;
		word_t data;
		logic last;
	} fill_word_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [ADDR_WIDTH-1:0] paddr;
		word_t pwdata;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic pready;
	} apb_rsp_t;

	function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
			input logic [3:0] be);
		word_t result;
		result = old_word;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				result[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return result;
	endfunction

endpackage

/* source/way_store.sv */
`timescale 1ns/1ps

module way_store import dcache_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input index_t i_rd_index,
	input way_wr_t i_wr,
	output tag_t [NUM_WAYS-1:0] o_tags,
	output logic [NUM_WAYS-1:0] o_valids,
	output logic [NUM_WAYS-1:0] o_dirties,
	output line_t [NUM_WAYS-1:0] o_lines
);

	tag_t r_tags [NUM_WAYS][NUM_SETS];
	line_t r_lines [NUM_WAYS][NUM_SETS];
	logic [NUM_WAYS-1:0][NUM_SETS-1:0] r_valid;
	logic [NUM_WAYS-1:0][NUM_SETS-1:0] r_dirty;
	logic [NUM_WAYS-1:0] w_fwd;

	// write of the set being read this cycle
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			w_fwd[w] = i_wr.we && i_wr.way == way_t'(w) && i_wr.index == i_rd_index;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_wr.we) begin
			r_tags[i_wr.way][i_wr.index] <= i_wr.tag;
			r_lines[i_wr.way][i_wr.index] <= i_wr.line;
		end
		for (int w = 0; w < NUM_WAYS; w++) begin
			o_tags[w] <= w_fwd[w] ? i_wr.tag : r_tags[w][i_rd_index];
			o_lines[w] <= w_fwd[w] ? i_wr.line : r_lines[w][i_rd_index];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_valid <= '0;
			r_dirty <= '0;
			o_valids <= '0;
			o_dirties <= '0;
		end else begin
			if (i_wr.we) begin
				r_valid[i_wr.way][i_wr.index] <= i_wr.valid;
				r_dirty[i_wr.way][i_wr.index] <= i_wr.dirty;
			end
			for (int w = 0; w < NUM_WAYS; w++) begin
				o_valids[w] <= w_fwd[w] ? i_wr.valid : r_valid[w][i_rd_index];
				o_dirties[w] <= w_fwd[w] ? i_wr.dirty : r_dirty[w][i_rd_index];
			end
		end
	end

endmodule

/* source/plru_table.sv */
`timescale 1ns/1ps

module plru_table import dcache_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input index_t i_index,
	input logic i_touch,
	input way_t i_touch_way,
	output way_t o_victim_way
);

	// bit 0 picks the half, bits 1 and 2 pick the way in each half
	logic [NUM_SETS-1:0][PLRU_WIDTH-1:0] r_bits;
	index_t r_index;
	logic [PLRU_WIDTH-1:0] w_cur;

	assign w_cur = r_bits[r_index];
	assign o_victim_way = w_cur[0] ? {1'b1, w_cur[2]} : {1'b0, w_cur[1]};

	always_ff @(posedge i_clk) begin
		r_index <= i_index;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_bits <= '0;
		end else if (i_touch) begin
			// point every level away from the touched way
			r_bits[r_index][0] <= ~i_touch_way[1];
			if (i_touch_way[1]) begin
				r_bits[r_index][2] <= ~i_touch_way[0];
			end else begin
				r_bits[r_index][1] <= ~i_touch_way[0];
			end
		end
	end

endmodule

/* source/victim_buffer.sv */
`timescale 1ns/1ps

module victim_buffer import dcache_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input victim_t i_push,
	output logic o_full,
	output victim_t o_head,
	input logic i_pop
);

	logic [ADDR_WIDTH-1:0] r_addrs [VICTIM_DEPTH];
	line_t r_lines [VICTIM_DEPTH];
	// extra top bit tells full from empty
	logic [VICTIM_PTR_WIDTH:0] r_wr_ptr, r_rd_ptr;
	logic w_empty;

	assign w_empty = (r_wr_ptr == r_rd_ptr);
	assign o_full = (r_wr_ptr[VICTIM_PTR_WIDTH] != r_rd_ptr[VICTIM_PTR_WIDTH])
		&& (r_wr_ptr[VICTIM_PTR_WIDTH-1:0] == r_rd_ptr[VICTIM_PTR_WIDTH-1:0]);

	assign o_head.valid = !w_empty;
	assign o_head.addr = r_addrs[r_rd_ptr[VICTIM_PTR_WIDTH-1:0]];
	assign o_head.line = r_lines[r_rd_ptr[VICTIM_PTR_WIDTH-1:0]];

	always_ff @(posedge i_clk) begin
		if (i_push.valid) begin
			r_addrs[r_wr_ptr[VICTIM_PTR_WIDTH-1:0]] <= i_push.addr;
			r_lines[r_wr_ptr[VICTIM_PTR_WIDTH-1:0]] <= i_push.line;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
		end else begin
			if (i_push.valid) begin
				r_wr_ptr <= r_wr_ptr + 1'b1;
			end
			if (i_pop) begin
				r_rd_ptr <= r_rd_ptr + 1'b1;
			end
		end
	end

	a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
		i_push.valid |-> !o_full)
		else $error("victim pushed into a full queue");

	a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst)
		i_pop |-> !w_empty)
		else $error("victim popped from an empty queue");

endmodule

/* source/mem_port.sv */
`timescale 1ns/1ps

module mem_port import dcache_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input victim_t i_head,
	output logic o_pop,
	input fill_req_t i_fill_req,
	output fill_word_t o_fill,
	output apb_req_t o_apb,
	input apb_rsp_t i_apb
);

	typedef enum logic [1:0] {
		MP_IDLE,
		MP_SETUP,
		MP_ACCESS
	} mp_state_t;

	mp_state_t r_state;
	logic r_write;
	logic [OFFSET_WIDTH-1:0] r_word_cnt;
	logic [ADDR_WIDTH-LINE_OFFSET_WIDTH-1:0] r_line_addr;
	logic w_done, w_last;

	assign w_done = (r_state == MP_ACCESS) && i_apb.pready;
	assign w_last = &r_word_cnt;

	assign o_apb.psel = (r_state != MP_IDLE);
	assign o_apb.penable = (r_state == MP_ACCESS);
	assign o_apb.pwrite = r_write;
	assign o_apb.paddr = {r_line_addr, r_word_cnt, 2'b00};
	// head entry stays put until its last word is popped
	assign o_apb.pwdata = i_head.line[r_word_cnt];

	assign o_fill.valid = w_done && !r_write;
	assign o_fill.data = i_apb.prdata;
	assign o_fill.last = w_last;
	assign o_pop = w_done && r_write && w_last;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= MP_IDLE;
			r_write <= 1'b0;
			r_word_cnt <= '0;
		end else begin
			case (r_state)
				MP_IDLE: begin
					r_word_cnt <= '0;
					// dirty victims drain before any refill
					if (i_head.valid) begin
						r_write <= 1'b1;
						r_state <= MP_SETUP;
					end else if (i_fill_req.valid) begin
						r_write <= 1'b0;
						r_state <= MP_SETUP;
					end
				end
				MP_SETUP: r_state <= MP_ACCESS;
				MP_ACCESS: begin
					if (i_apb.pready) begin
						r_word_cnt <= r_word_cnt + 1'b1;
						r_state <= w_last ? MP_IDLE : MP_SETUP;
					end
				end
				default: r_state <= MP_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (r_state == MP_IDLE) begin
			r_line_addr <= i_head.valid ? i_head.addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH]
				: i_fill_req.addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH];
		end
	end

	a_apb_setup: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(o_apb.penable) |-> $past(o_apb.psel && !o_apb.penable))
		else $error("penable raised without a setup cycle");

endmodule

/* source/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input cpu_req_t i_req,
	output logic o_req_ready,
	output cpu_rsp_t o_rsp,
	output index_t o_rd_index,
	input tag_t [NUM_WAYS-1:0] i_tags,
	input logic [NUM_WAYS-1:0] i_valids,
	input logic [NUM_WAYS-1:0] i_dirties,
	input line_t [NUM_WAYS-1:0] i_lines,
	output way_wr_t o_wr,
	output logic o_touch,
	output way_t o_touch_way,
	input way_t i_victim_way,
	output victim_t o_push,
	input logic i_full,
	output fill_req_t o_fill_req,
	input fill_word_t i_fill
);

	ctrl_state_t r_state, w_next;
	cpu_req_t r_req;
	way_t r_way;
	logic [OFFSET_WIDTH-1:0] r_fill_cnt;
	line_t r_fill_line;

	tag_t w_req_tag;
	index_t w_req_index;
	logic [OFFSET_WIDTH-1:0] w_req_offset;
	logic w_hit, w_lookup_hit, w_fill_done, w_accept;
	way_t w_hit_way;
	line_t w_fill_line, w_src_line, w_new_line;

	assign w_req_tag = r_req.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
	assign w_req_index = r_req.addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
	assign w_req_offset = r_req.addr[2 +: OFFSET_WIDTH];

	// tag compare over all ways
	always_comb begin
		w_hit = 1'b0;
		w_hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (i_valids[w] && i_tags[w] == w_req_tag) begin
				w_hit = 1'b1;
				w_hit_way = way_t'(w);
			end
		end
	end

	assign w_lookup_hit = (r_state == LOOKUP) && w_hit;
	assign w_fill_done = (r_state == REFILL) && i_fill.valid && i_fill.last;
	assign o_req_ready = (r_state == IDLE) || w_lookup_hit;
	assign w_accept = i_req.valid && o_req_ready;

	// hold the set while a miss is in progress
	assign o_rd_index = o_req_ready ? i_req.addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH] : w_req_index;

	// refill line with the word arriving this cycle
	always_comb begin
		w_fill_line = r_fill_line;
		w_fill_line[r_fill_cnt] = i_fill.data;
	end

	always_comb begin
		w_src_line = (r_state == REFILL) ? w_fill_line : i_lines[w_hit_way];
		w_new_line = w_src_line;
		if (r_req.write) begin
			w_new_line[w_req_offset] = merge_bytes(w_src_line[w_req_offset], r_req.wdata,
				r_req.be);
		end
	end

	assign o_rsp.valid = w_lookup_hit || w_fill_done;
	assign o_rsp.rdata = w_src_line[w_req_offset];

	assign o_touch = w_lookup_hit || w_fill_done;
	assign o_touch_way = w_fill_done ? r_way : w_hit_way;

	always_comb begin
		o_wr = '0;
		o_wr.way = w_fill_done ? r_way : w_hit_way;
		o_wr.index = w_req_index;
		o_wr.tag = w_req_tag;
		o_wr.line = w_new_line;
		o_wr.valid = 1'b1;
		o_wr.dirty = r_req.write;
		// store hits write back, refills always install
		o_wr.we = (w_lookup_hit && r_req.write) || w_fill_done;
	end

	assign o_push.valid = (r_state == EVICT) && !i_full;
	assign o_push.addr = {i_tags[r_way], w_req_index, {LINE_OFFSET_WIDTH{1'b0}}};
	assign o_push.line = i_lines[r_way];

	assign o_fill_req.valid = (r_state == REFILL);
	assign o_fill_req.addr = {r_req.addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH],
		{LINE_OFFSET_WIDTH{1'b0}}};

	always_comb begin
		w_next = r_state;
		case (r_state)
			IDLE: begin
				if (i_req.valid) begin
					w_next = LOOKUP;
				end
			end
			LOOKUP: begin
				if (w_hit) begin
					w_next = i_req.valid ? LOOKUP : IDLE;
				end else if (i_valids[i_victim_way] && i_dirties[i_victim_way]) begin
					w_next = EVICT;
				end else begin
					w_next = REFILL;
				end
			end
			EVICT: begin
				if (!i_full) begin
					w_next = REFILL;
				end
			end
			REFILL: begin
				if (w_fill_done) begin
					w_next = IDLE;
				end
			end
			default: w_next = IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= IDLE;
			r_fill_cnt <= '0;
		end else begin
			r_state <= w_next;
			if (r_state == REFILL && i_fill.valid) begin
				r_fill_cnt <= r_fill_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_accept) begin
			r_req <= i_req;
		end
		if (r_state == LOOKUP && !w_hit) begin
			r_way <= i_victim_way;
		end
		if (r_state == REFILL && i_fill.valid) begin
			r_fill_line[r_fill_cnt] <= i_fill.data;
		end
	end

	// a miss answers only with the final refill word
	a_rsp_state: assert property (@(posedge i_clk) disable iff (i_rst)
		o_rsp.valid |-> (r_state == LOOKUP) || (r_state == REFILL && &r_fill_cnt))
		else $error("response outside lookup or refill completion");

endmodule

/* source/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input cpu_req_t i_req,
	output logic o_req_ready,
	output cpu_rsp_t o_rsp,
	output apb_req_t o_apb,
	input apb_rsp_t i_apb
);

	index_t rd_index;
	tag_t [NUM_WAYS-1:0] tags;
	logic [NUM_WAYS-1:0] valids;
	logic [NUM_WAYS-1:0] dirties;
	line_t [NUM_WAYS-1:0] lines;
	way_wr_t wr;
	logic touch;
	way_t touch_way;
	way_t victim_way;
	victim_t push;
	logic full;
	victim_t head;
	logic pop;
	fill_req_t fill_req;
	fill_word_t fill;

	dcache_ctrl i_dcache_ctrl (
		.i_clk,
		.i_rst,
		.i_req,
		.o_req_ready,
		.o_rsp,
		.o_rd_index(rd_index),
		.i_tags(tags),
		.i_valids(valids),
		.i_dirties(dirties),
		.i_lines(lines),
		.o_wr(wr),
		.o_touch(touch),
		.o_touch_way(touch_way),
		.i_victim_way(victim_way),
		.o_push(push),
		.i_full(full),
		.o_fill_req(fill_req),
		.i_fill(fill)
	);

	way_store i_way_store (
		.i_clk,
		.i_rst,
		.i_rd_index(rd_index),
		.i_wr(wr),
		.o_tags(tags),
		.o_valids(valids),
		.o_dirties(dirties),
		.o_lines(lines)
	);

	// replacement tracks the same set the arrays are reading
	plru_table i_plru_table (
		.i_clk,
		.i_rst,
		.i_index(rd_index),
		.i_touch(touch),
		.i_touch_way(touch_way),
		.o_victim_way(victim_way)
	);

	victim_buffer i_victim_buffer (
		.i_clk,
		.i_rst,
		.i_push(push),
		.o_full(full),
		.o_head(head),
		.i_pop(pop)
	);

	mem_port i_mem_port (
		.i_clk,
		.i_rst,
		.i_head(head),
		.o_pop(pop),
		.i_fill_req(fill_req),
		.o_fill(fill),
		.o_apb,
		.i_apb
	);

endmodule

/* dv/apb_mem_model.sv */
`timescale 1ns/1ps

module apb_mem_model import dcache_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input apb_req_t i_apb,
	output apb_rsp_t o_apb
);

	localparam int MEM_WORDS = 4096;
	localparam int MEM_INDEX_WIDTH = $clog2(MEM_WORDS);
	localparam logic [31:0] SEED = 32'h7d46_adcf;

	word_t mem [MEM_WORDS];
	logic [31:0] r_rand;
	logic [31:0] w_next_rand;
	logic [1:0] r_wait;
	logic r_ready;
	logic [MEM_INDEX_WIDTH-1:0] w_index;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// every word starts as its own address with a marker
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = (32'(i) << 2) ^ 32'h5a5a_0000;
		end
	end

	assign w_index = i_apb.paddr[MEM_INDEX_WIDTH+1:2];
	assign w_next_rand = xorshift32(r_rand);
	assign o_apb.prdata = mem[w_index];
	assign o_apb.pready = r_ready;

	always @(posedge i_clk) begin
		if (i_rst) begin
			r_rand <= SEED;
			r_wait <= 2'd0;
			r_ready <= 1'b0;
		end else if (i_apb.psel && !i_apb.penable) begin
			// zero to three wait states for the coming access cycle
			r_rand <= w_next_rand;
			r_wait <= w_next_rand[1:0];
			r_ready <= (w_next_rand[1:0] == 2'd0);
		end else if (i_apb.psel && i_apb.penable) begin
			if (r_ready) begin
				if (i_apb.pwrite) begin
					mem[w_index] <= i_apb.pwdata;
				end
				r_ready <= 1'b0;
			end else begin
				r_wait <= r_wait - 2'd1;
				r_ready <= (r_wait == 2'd1);
			end
		end
	end

endmodule

/* dv/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

	localparam int MEM_WORDS = 4096;
	localparam int MEM_INDEX_WIDTH = $clog2(MEM_WORDS);
	localparam logic [31:0] SEED = 32'h7d46_adcf;
	localparam int RANDOM_OPS = 200;
	localparam int ACCESS_COUNT = 50 + RANDOM_OPS;
	// setup, access and up to three wait states
	localparam int APB_WORST_CYCLES = 5;
	// victim write back plus refill, and controller overhead
	localparam int MISS_CYCLES = 2 * WORDS_PER_LINE * APB_WORST_CYCLES + 8;
	localparam int CYCLE_LIMIT = 2 * ACCESS_COUNT * MISS_CYCLES + 16;

	logic i_clk;
	logic i_rst;
	cpu_req_t i_req;
	logic o_req_ready;
	cpu_rsp_t o_rsp;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	word_t ref_mem [MEM_WORDS];
	logic [31:0] rand_state;
	int cycle_count;
	int error_count;

	dcache_top i_dcache_top (
		.i_clk,
		.i_rst,
		.i_req,
		.o_req_ready,
		.o_rsp,
		.o_apb(apb_req),
		.i_apb(apb_rsp)
	);

	apb_mem_model mem_model (
		.i_clk,
		.i_rst,
		.i_apb(apb_req),
		.o_apb(apb_rsp)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge i_clk);
			cycle_count = cycle_count + 1;
		end
		$display("timeout: tests still running after %0d clock cycles", CYCLE_LIMIT);
		$display("Test failed");
		$fatal(1);
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rand_state = xorshift32(rand_state);
		return rand_state;
	endfunction

	function automatic int word_index(input logic [ADDR_WIDTH-1:0] addr);
		return int'(addr[MEM_INDEX_WIDTH+1:2]);
	endfunction

	// enabled byte lanes take the store data
	function automatic word_t store_result(input word_t old_word, input word_t new_word,
			input logic [3:0] be);
		word_t mask;
		mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		return (old_word & ~mask) | (new_word & mask);
	endfunction

	task automatic abort_run();
		error_count = error_count + 1;
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_valid(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// starts and ends on a falling edge
	task automatic issue_access(input logic write, input logic [ADDR_WIDTH-1:0] addr,
			input word_t wdata, input logic [3:0] be, output word_t rdata, output int latency);
		i_req.valid = 1'b1;
		i_req.write = write;
		i_req.addr = addr;
		i_req.wdata = wdata;
		i_req.be = be;
		while (!o_req_ready) begin
			@(negedge i_clk);
		end
		@(negedge i_clk);
		i_req = '0;
		latency = 1;
		while (!o_rsp.valid) begin
			@(negedge i_clk);
			latency = latency + 1;
		end
		rdata = o_rsp.rdata;
		// one response per request
		@(negedge i_clk);
		compare_valid("o_rsp.valid", o_rsp.valid, 1'b0);
	endtask

	task automatic load_check(input logic [ADDR_WIDTH-1:0] addr, output int latency);
		word_t rdata;
		issue_access(1'b0, addr, '0, 4'b0000, rdata, latency);
		compare_word($sformatf("o_rsp.rdata (load %h)", addr), rdata, ref_mem[word_index(addr)]);
	endtask

	task automatic store_word(input logic [ADDR_WIDTH-1:0] addr, input word_t wdata,
			input logic [3:0] be, output int latency);
		word_t rdata;
		issue_access(1'b1, addr, wdata, be, rdata, latency);
		ref_mem[word_index(addr)] = store_result(ref_mem[word_index(addr)], wdata, be);
	endtask

	task automatic reset_state_test();
		compare_valid("o_req_ready", o_req_ready, 1'b1);
		compare_valid("o_rsp.valid", o_rsp.valid, 1'b0);
		compare_valid("o_apb.psel", apb_req.psel, 1'b0);
		compare_valid("o_apb.penable", apb_req.penable, 1'b0);
	endtask

	task automatic read_miss_test();
		int latency;
		load_check(32'h0000_0100, latency);
		// four refill transfers of at least two cycles each
		if (latency <= 2 * WORDS_PER_LINE) begin
			$display("read miss answered after %0d cycles, too early for a refill", latency);
			abort_run();
		end
	endtask

	task automatic back_to_back_test();
		logic [ADDR_WIDTH-1:0] base;
		int latency;
		base = 32'h0000_0200;
		load_check(base, latency);
		for (int k = 0; k <= WORDS_PER_LINE; k++) begin
			if (k > 0) begin
				compare_valid("o_rsp.valid", o_rsp.valid, 1'b1);
				compare_word("o_rsp.rdata", o_rsp.rdata,
					ref_mem[word_index(base + (32'(k - 1) << 2))]);
			end
			if (k < WORDS_PER_LINE) begin
				i_req.valid = 1'b1;
				i_req.write = 1'b0;
				i_req.addr = base + (32'(k) << 2);
				compare_valid("o_req_ready", o_req_ready, 1'b1);
			end else begin
				i_req = '0;
			end
			@(negedge i_clk);
		end
		compare_valid("o_rsp.valid", o_rsp.valid, 1'b0);
	endtask

	task automatic partial_store_test();
		int latency;
		// line at 0x200 is already cached
		store_word(32'h0000_0208, 32'hdead_beef, 4'b0101, latency);
		if (latency != 1) begin
			$display("store hit answered after %0d cycles instead of one", latency);
			abort_run();
		end
		load_check(32'h0000_0208, latency);
		// store miss allocates the line first
		store_word(32'h0000_03a4, 32'hcafe_f00d, 4'b1010, latency);
		load_check(32'h0000_03a4, latency);
		load_check(32'h0000_03a0, latency);
		store_word(32'h0000_03a4, 32'h0bad_0bad, 4'b0001, latency);
		load_check(32'h0000_03a4, latency);
	endtask

	task automatic eviction_test();
		logic [ADDR_WIDTH-1:0] addr;
		int latency;
		// all lines below map to set 5
		for (int k = 0; k < 5; k++) begin
			addr = 32'h0000_0054 + (32'(k) << 8);
			store_word(addr, 32'h1111_0000 + 32'(k), 4'b1111, latency);
		end
		for (int k = 0; k < 5; k++) begin
			for (int w = 0; w < WORDS_PER_LINE; w++) begin
				load_check(32'h0000_0050 + (32'(k) << 8) + (32'(w) << 2), latency);
			end
		end
		// four clean misses replace every way of the set
		for (int k = 5; k < 9; k++) begin
			load_check(32'h0000_0050 + (32'(k) << 8), latency);
		end
		for (int k = 0; k < 5; k++) begin
			for (int w = 0; w < WORDS_PER_LINE; w++) begin
				addr = 32'h0000_0050 + (32'(k) << 8) + (32'(w) << 2);
				compare_word($sformatf("mem_model.mem[%0d]", word_index(addr)),
					mem_model.mem[word_index(addr)], ref_mem[word_index(addr)]);
			end
		end
	endtask

	task automatic random_mix_test();
		logic [31:0] r;
		word_t wdata;
		logic [ADDR_WIDTH-1:0] addr;
		int latency;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			r = next_random();
			// 4 KB window holds sixteen lines per set
			addr = r & 32'h0000_0ffc;
			if (r[31]) begin
				wdata = next_random();
				store_word(addr, wdata, r[19:16], latency);
			end else begin
				load_check(addr, latency);
			end
		end
	endtask

	initial begin
		error_count = 0;
		rand_state = SEED;
		i_rst = 1'b1;
		i_req = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = (32'(i) << 2) ^ 32'h5a5a_0000;
		end
		repeat (8) @(negedge i_clk);
		i_rst = 1'b0;
		reset_state_test();
		read_miss_test();
		back_to_back_test();
		partial_store_test();
		eviction_test();
		random_mix_test();
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* sim.f */
source/dcache_pkg.sv
source/way_store.sv
source/plru_table.sv
source/victim_buffer.sv
source/mem_port.sv
source/dcache_ctrl.sv
source/dcache_top.sv
dv/apb_mem_model.sv
dv/tb_dcache.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f sim.f \
	&& ./obj_dir/Vtb_dcache 2>&1 | tee sim.log \
	|| { echo "build or run error"; exit 1; }
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
